// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_ui_cmd
FILELIST ?= tb.f

PASS_MSG := Simulation completed successfully
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BUILD    := build

ORDER_brc := 0
ORDER_rbc := 1

BINS := $(BUILD)/brc/V$(TOP) $(BUILD)/rbc/V$(TOP)

.PHONY: all run clean

all: $(BINS)

$(BUILD)/%/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -GADDR_ORDER=$(ORDER_$*) \
		-f $(FILELIST) --Mdir $(BUILD)/$* -o V$(TOP)

run: $(BINS)
	@for b in $(BINS); do \
		echo "Running $$b"; \
		out=$$(./$$b); \
		echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)" || exit 1; \
	done

clean:
	rm -rf $(BUILD)

// File: rtl/ui_cmd_issue.sv
// Issue stage: address decode, use_addr, read/write acceptance, data-buffer address select
`timescale 1ns/1ns
`default_nettype none

module ui_cmd_issue import ui_cmd_pkg::*; #(
  parameter int ADDR_ORDER = ORDER_BANK_ROW_COLUMN
) (
  ui_stage_if.issue                      stg,
  input  logic [DATA_BUF_ADDR_WIDTH-1:0] wr_data_buf_addr,
  input  logic [DATA_BUF_ADDR_WIDTH-1:0] rd_data_buf_addr_r,
  output logic                           use_addr,
  output logic [RANK_WIDTH-1:0]          rank,
  output logic [GROUP_WIDTH-1:0]         group,
  output logic [BANK_WIDTH-1:0]          bank,
  output logic [ROW_WIDTH-1:0]           row,
  output logic [COL_WIDTH-1:0]           col,
  output logic                           size,
  output logic [CMD_WIDTH-1:0]           cmd,
  output logic                           hi_priority,
  output logic                           autoprecharge,
  output logic                           rd_accepted,
  output logic                           wr_accepted,
  output logic [DATA_BUF_ADDR_WIDTH-1:0] data_buf_addr
);

  logic s2_rd;
  logic s2_wr;
  logic s2_wr_bytes;
  logic s2_write;

  // ************************************************************************
  // Address decode of the presented request
  // ************************************************************************
  always_comb begin
    if (ADDR_ORDER == ORDER_ROW_BANK_COLUMN) begin
      rank  = stg.pres_addr.rbc.rank;
      group = stg.pres_addr.rbc.group;
      bank  = stg.pres_addr.rbc.bank;
      row   = stg.pres_addr.rbc.row;
      col   = stg.pres_addr.rbc.col;
    end else begin
      // Bank-row-column, also the fallback for unknown orders
      rank  = stg.pres_addr.brc.rank;
      group = stg.pres_addr.brc.group;
      bank  = stg.pres_addr.brc.bank;
      row   = stg.pres_addr.brc.row;
      col   = stg.pres_addr.brc.col;
    end
  end

  assign size          = stg.pres_sz;
  assign cmd           = stg.pres_cmd;
  assign hi_priority   = stg.pres_hi_pri;
  assign autoprecharge = stg.pres_autoprecharge;

  // ************************************************************************
  // Consumption of the stage-2 request
  // ************************************************************************
  assign use_addr = stg.s2_valid & stg.rdy;

  // Classification on the low command bits
  assign s2_rd       = stg.s2_cmd[1:0] == CMD_RD;
  assign s2_wr       = stg.s2_cmd[1:0] == CMD_WR;
  assign s2_wr_bytes = stg.s2_cmd[1:0] == CMD_WR_BYTES;
  assign s2_write    = s2_wr | s2_wr_bytes;

  assign rd_accepted = use_addr & s2_rd;
  assign wr_accepted = use_addr & s2_write;

  // Writes point at the write buffer, everything else at the read buffer
  assign data_buf_addr = s2_write ? wr_data_buf_addr : rd_data_buf_addr_r;

  // ************************************************************************
  // Assertions
  // ************************************************************************
  a_rd_wr_onehot: assert property (
    @(posedge stg.clk)
    !(rd_accepted && wr_accepted)
  );

  // Consumption only while the pipeline is advancing
  a_use_needs_rdy: assert property (
    @(posedge stg.clk)
    use_addr |-> stg.rdy
  );

endmodule

`default_nettype wire

// File: rtl/ui_cmd_pipe.sv
// Ready register, two-stage request pipeline, look-ahead select and busy flag
`timescale 1ns/1ns
`default_nettype none

module ui_cmd_pipe import ui_cmd_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  ui_addr_u             app_addr,
  input  logic [CMD_WIDTH-1:0] app_cmd,
  input  logic                 app_sz,
  input  logic                 app_hi_pri,
  input  logic                 app_autoprecharge,
  input  logic                 app_en,
  input  logic                 accept_ns,
  input  logic                 rd_buf_full,
  input  logic                 wr_req_16,
  input  logic                 mc_block_req,
  output logic                 app_rdy,
  output logic                 ui_busy,
  ui_stage_if.pipe             stg
);

  logic                 app_rdy_ns;
  logic                 app_req;

  // Stage 1
  logic                 s1_valid;
  ui_addr_u             s1_addr;
  logic [CMD_WIDTH-1:0] s1_cmd;
  logic                 s1_sz;
  logic                 s1_hi_pri;
  logic                 s1_autoprecharge;

  // Stage 2
  logic                 s2_valid;
  ui_addr_u             s2_addr;
  logic [CMD_WIDTH-1:0] s2_cmd;
  logic                 s2_sz;
  logic                 s2_hi_pri;
  logic                 s2_autoprecharge;

  // ************************************************************************
  // Ready register
  // ************************************************************************
  assign app_rdy_ns = accept_ns & ~rd_buf_full & ~wr_req_16 & ~mc_block_req;

  // A request arriving from the user side, taken only if app_rdy is high
  assign app_req = app_en & ~mc_block_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      app_rdy <= 1'b0;
    end else begin
      app_rdy <= app_rdy_ns;
    end
  end

  // ************************************************************************
  // Request pipeline, advances only while app_rdy is high
  // ************************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (app_rdy) begin
      s1_valid <= app_req;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (app_rdy) begin
      s1_addr          <= app_addr;
      s1_cmd           <= app_cmd;
      s1_sz            <= app_sz;
      s1_hi_pri        <= app_hi_pri;
      s1_autoprecharge <= app_autoprecharge;
      s2_addr          <= s1_addr;
      s2_cmd           <= s1_cmd;
      s2_sz            <= s1_sz;
      s2_hi_pri        <= s1_hi_pri;
      s2_autoprecharge <= s1_autoprecharge;
    end
  end

  // Look-ahead: with app_rdy high stage 1 moves to stage 2 on this edge
  assign stg.rdy                = app_rdy;
  assign stg.pres_addr          = app_rdy ? s1_addr : s2_addr;
  assign stg.pres_cmd           = app_rdy ? s1_cmd : s2_cmd;
  assign stg.pres_sz            = app_rdy ? s1_sz : s2_sz;
  assign stg.pres_hi_pri        = app_rdy ? s1_hi_pri : s2_hi_pri;
  assign stg.pres_autoprecharge = app_rdy ? s1_autoprecharge : s2_autoprecharge;
  assign stg.s2_valid           = s2_valid;
  assign stg.s2_cmd             = s2_cmd;

  // Pending or arriving work
  assign ui_busy = app_req | s1_valid | s2_valid;

  // ************************************************************************
  // Assertions
  // ************************************************************************
  // A block request must close the user side on the next cycle
  a_block_drops_rdy: assert property (
    @(posedge clk) disable iff (rst)
    mc_block_req |=> !app_rdy
  );

  // Stage 2 is only ever filled from a valid stage 1
  a_s2_from_s1: assert property (
    @(posedge clk) disable iff (rst)
    (app_rdy && !s1_valid) |=> !s2_valid
  );

endmodule

`default_nettype wire

// File: rtl/ui_cmd_pkg.sv
// Command port package: field widths, field positions, order constants, command codes, address union
`default_nettype none

package ui_cmd_pkg;

  // ************************************************************************
  // Field widths
  // ************************************************************************
  localparam int ADDR_WIDTH          = 29;
  localparam int COL_WIDTH           = 10;
  localparam int ROW_WIDTH           = 14;
  localparam int BANK_WIDTH          = 2;
  localparam int GROUP_WIDTH         = 2;
  localparam int RANK_WIDTH          = 1;
  localparam int CMD_WIDTH           = 3;
  localparam int DATA_BUF_ADDR_WIDTH = 5;

  // Values of ADDR_ORDER
  localparam int ORDER_BANK_ROW_COLUMN = 0;
  localparam int ORDER_ROW_BANK_COLUMN = 1;

  // Low two command bits
  localparam logic [1:0] CMD_WR       = 2'b00;
  localparam logic [1:0] CMD_RD       = 2'b01;
  localparam logic [1:0] CMD_WR_BYTES = 2'b11;

  // ************************************************************************
  // Address word, decoded in either order
  // ************************************************************************
  typedef struct packed {
    logic [RANK_WIDTH-1:0]  rank;
    logic [GROUP_WIDTH-1:0] group;
    logic [BANK_WIDTH-1:0]  bank;
    logic [ROW_WIDTH-1:0]   row;
    logic [COL_WIDTH-1:0]   col;
  } ui_addr_brc_t;

  typedef struct packed {
    logic [RANK_WIDTH-1:0]  rank;
    logic [ROW_WIDTH-1:0]   row;
    logic [GROUP_WIDTH-1:0] group;
    logic [BANK_WIDTH-1:0]  bank;
    logic [COL_WIDTH-1:0]   col;
  } ui_addr_rbc_t;

  typedef union packed {
    ui_addr_brc_t brc;
    ui_addr_rbc_t rbc;
  } ui_addr_u;

endpackage

`default_nettype wire

// File: rtl/ui_cmd_top.sv
// Command port top level: plain ports, stage interface, pipeline and issue stage
`timescale 1ns/1ns
`default_nettype none

module ui_cmd_top import ui_cmd_pkg::*; #(
  parameter int ADDR_ORDER = ORDER_BANK_ROW_COLUMN
) (
  input  logic                           clk,
  input  logic                           rst,
  // User side
  input  logic [ADDR_WIDTH-1:0]          app_addr,
  input  logic [CMD_WIDTH-1:0]           app_cmd,
  input  logic                           app_sz,
  input  logic                           app_hi_pri,
  input  logic                           app_autoprecharge,
  input  logic                           app_en,
  output logic                           app_rdy,
  // Controller status
  input  logic                           accept_ns,
  input  logic                           rd_buf_full,
  input  logic                           wr_req_16,
  input  logic                           mc_block_req,
  input  logic [DATA_BUF_ADDR_WIDTH-1:0] wr_data_buf_addr,
  input  logic [DATA_BUF_ADDR_WIDTH-1:0] rd_data_buf_addr_r,
  // Request to the controller
  output logic                           use_addr,
  output logic [RANK_WIDTH-1:0]          rank,
  output logic [GROUP_WIDTH-1:0]         group,
  output logic [BANK_WIDTH-1:0]          bank,
  output logic [ROW_WIDTH-1:0]           row,
  output logic [COL_WIDTH-1:0]           col,
  output logic                           size,
  output logic [CMD_WIDTH-1:0]           cmd,
  output logic                           hi_priority,
  output logic                           autoprecharge,
  output logic                           rd_accepted,
  output logic                           wr_accepted,
  output logic [DATA_BUF_ADDR_WIDTH-1:0] data_buf_addr,
  output logic                           ui_busy
);

  ui_stage_if stg (.clk(clk));

  ui_cmd_pipe u_pipe (
    .clk               (clk),
    .rst               (rst),
    .app_addr          (app_addr),
    .app_cmd           (app_cmd),
    .app_sz            (app_sz),
    .app_hi_pri        (app_hi_pri),
    .app_autoprecharge (app_autoprecharge),
    .app_en            (app_en),
    .accept_ns         (accept_ns),
    .rd_buf_full       (rd_buf_full),
    .wr_req_16         (wr_req_16),
    .mc_block_req      (mc_block_req),
    .app_rdy           (app_rdy),
    .ui_busy           (ui_busy),
    .stg               (stg.pipe)
  );

  ui_cmd_issue #(
    .ADDR_ORDER (ADDR_ORDER)
  ) u_issue (
    .stg                (stg.issue),
    .wr_data_buf_addr   (wr_data_buf_addr),
    .rd_data_buf_addr_r (rd_data_buf_addr_r),
    .use_addr           (use_addr),
    .rank               (rank),
    .group              (group),
    .bank               (bank),
    .row                (row),
    .col                (col),
    .size               (size),
    .cmd                (cmd),
    .hi_priority        (hi_priority),
    .autoprecharge      (autoprecharge),
    .rd_accepted        (rd_accepted),
    .wr_accepted        (wr_accepted),
    .data_buf_addr      (data_buf_addr)
  );

endmodule

`default_nettype wire

// File: rtl/ui_stage_if.sv
// Interface between pipeline and issue stage: ready, presented request, stage-2 status
`timescale 1ns/1ns
`default_nettype none

interface ui_stage_if import ui_cmd_pkg::*; (
  input logic clk
);

  // Registered app_rdy
  logic                 rdy;

  // Look-ahead request, stage 1 or stage 2
  ui_addr_u             pres_addr;
  logic [CMD_WIDTH-1:0] pres_cmd;
  logic                 pres_sz;
  logic                 pres_hi_pri;
  logic                 pres_autoprecharge;

  // Request about to be consumed
  logic                 s2_valid;
  logic [CMD_WIDTH-1:0] s2_cmd;

  modport pipe (
    output rdy, pres_addr, pres_cmd, pres_sz, pres_hi_pri, pres_autoprecharge,
    output s2_valid, s2_cmd
  );

  modport issue (
    input clk,
    input rdy, pres_addr, pres_cmd, pres_sz, pres_hi_pri, pres_autoprecharge,
    input s2_valid, s2_cmd
  );

endinterface

`default_nettype wire

// File: tb.f
rtl/ui_cmd_pkg.sv
rtl/ui_stage_if.sv
rtl/ui_cmd_pipe.sv
rtl/ui_cmd_issue.sv
rtl/ui_cmd_top.sv
tb/tb_ui_cmd.sv

// File: tb/tb_ui_cmd.sv
// Testbench for the command port: clock, reset, LFSR stimulus, reference model, checks, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_ui_cmd import ui_cmd_pkg::*; #(
  parameter int ADDR_ORDER = ORDER_BANK_ROW_COLUMN
);

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_CYCLES   = 2000;
  localparam int          DRAIN_CYCLES = 8;
  localparam int          WATCHDOG_NS  =
    (RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES) * CLK_PERIOD + 400;
  localparam logic [31:0] LFSR_SEED    = 32'hbb62_72f1;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [CMD_WIDTH-1:0]  cmd;
    logic                  sz;
    logic                  hi_pri;
    logic                  ap;
  } req_t;

  // DUT ports
  logic                           clk;
  logic                           rst;
  logic [ADDR_WIDTH-1:0]          app_addr;
  logic [CMD_WIDTH-1:0]           app_cmd;
  logic                           app_sz;
  logic                           app_hi_pri;
  logic                           app_autoprecharge;
  logic                           app_en;
  logic                           app_rdy;
  logic                           accept_ns;
  logic                           rd_buf_full;
  logic                           wr_req_16;
  logic                           mc_block_req;
  logic [DATA_BUF_ADDR_WIDTH-1:0] wr_data_buf_addr;
  logic [DATA_BUF_ADDR_WIDTH-1:0] rd_data_buf_addr_r;
  logic                           use_addr;
  logic [RANK_WIDTH-1:0]          rank;
  logic [GROUP_WIDTH-1:0]         group;
  logic [BANK_WIDTH-1:0]          bank;
  logic [ROW_WIDTH-1:0]           row;
  logic [COL_WIDTH-1:0]           col;
  logic                           size;
  logic [CMD_WIDTH-1:0]           cmd;
  logic                           hi_priority;
  logic                           autoprecharge;
  logic                           rd_accepted;
  logic                           wr_accepted;
  logic [DATA_BUF_ADDR_WIDTH-1:0] data_buf_addr;
  logic                           ui_busy;

  // Reference model state, as it stands after the most recent rising edge
  logic                 m_rdy;
  logic                 m_s1_valid;
  logic                 m_s2_valid;
  req_t                 m_s1;
  req_t                 m_s2;
  logic [CMD_WIDTH-1:0] pend_q[$];

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          consumed;

  ui_cmd_top #(
    .ADDR_ORDER (ADDR_ORDER)
  ) uut (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // **************************************************************************
  // Stimulus helpers
  // **************************************************************************
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ LFSR_TAPS;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic drive_idle(input logic accept);
    app_en             = 1'b0;
    app_addr           = '0;
    app_cmd            = '0;
    app_sz             = 1'b0;
    app_hi_pri         = 1'b0;
    app_autoprecharge  = 1'b0;
    accept_ns          = accept;
    rd_buf_full        = 1'b0;
    wr_req_16          = 1'b0;
    mc_block_req       = 1'b0;
    wr_data_buf_addr   = '0;
    rd_data_buf_addr_r = '0;
  endtask

  task automatic drive_random(input int cyc);
    app_en = take_bits(2) != 0;
    // Long stall of the controller every 400 cycles
    if ((cyc % 400) >= 200 && (cyc % 400) < 230) accept_ns = 1'b0;
    else accept_ns = take_bits(3) != 0;
    rd_buf_full        = take_bits(4) == 0;
    wr_req_16          = take_bits(4) == 0;
    mc_block_req       = take_bits(5) == 0;
    app_addr           = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
    app_cmd            = CMD_WIDTH'(take_bits(CMD_WIDTH));
    app_sz             = take_bits(1) != 0;
    app_hi_pri         = take_bits(1) != 0;
    app_autoprecharge  = take_bits(1) != 0;
    wr_data_buf_addr   = DATA_BUF_ADDR_WIDTH'(take_bits(DATA_BUF_ADDR_WIDTH));
    rd_data_buf_addr_r = DATA_BUF_ADDR_WIDTH'(take_bits(DATA_BUF_ADDR_WIDTH));
  endtask

  // **************************************************************************
  // Reference model
  // **************************************************************************
  // Effect of the coming rising edge, given the inputs just driven
  task automatic update_model();
    if (m_rdy && app_en && !mc_block_req) pend_q.push_back(app_cmd);
    if (m_rdy) begin
      m_s2_valid = m_s1_valid;
      m_s2       = m_s1;
      m_s1_valid = app_en & ~mc_block_req;
      m_s1       = '{addr: app_addr, cmd: app_cmd, sz: app_sz,
                     hi_pri: app_hi_pri, ap: app_autoprecharge};
    end
    m_rdy = accept_ns & ~rd_buf_full & ~wr_req_16 & ~mc_block_req;
  endtask

  task automatic decode_addr(
    input  logic [ADDR_WIDTH-1:0]  a,
    output logic [RANK_WIDTH-1:0]  rk,
    output logic [GROUP_WIDTH-1:0] grp,
    output logic [BANK_WIDTH-1:0]  bk,
    output logic [ROW_WIDTH-1:0]   rw,
    output logic [COL_WIDTH-1:0]   cl
  );
    rk = a[28];
    if (ADDR_ORDER == ORDER_ROW_BANK_COLUMN) begin
      rw  = a[27:14];
      grp = a[13:12];
      bk  = a[11:10];
    end else begin
      grp = a[27:26];
      bk  = a[25:24];
      rw  = a[23:10];
    end
    cl = a[9:0];
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
    end
  endtask

  // Outputs are stable here, between the rising edge and the next drive
  task automatic check_outputs();
    req_t                   pres;
    logic                   pres_valid;
    logic [CMD_WIDTH-1:0]   head;
    logic                   is_rd;
    logic                   is_wr;
    logic [RANK_WIDTH-1:0]  e_rank;
    logic [GROUP_WIDTH-1:0] e_group;
    logic [BANK_WIDTH-1:0]  e_bank;
    logic [ROW_WIDTH-1:0]   e_row;
    logic [COL_WIDTH-1:0]   e_col;
    check_value("app_rdy", 32'(app_rdy), 32'(m_rdy));
    check_value("use_addr", 32'(use_addr), 32'(m_s2_valid & m_rdy));
    check_value("ui_busy", 32'(ui_busy),
                32'((app_en & ~mc_block_req) | m_s1_valid | m_s2_valid));
    if (use_addr) begin
      assert (pend_q.size() > 0) else begin
        errors++;
        $display("use_addr pulsed at %0t with no accepted request pending", $time);
      end
      if (pend_q.size() > 0) begin
        head = pend_q.pop_front();
        consumed++;
        is_rd = head[1:0] == CMD_RD;
        is_wr = (head[1:0] == CMD_WR) || (head[1:0] == CMD_WR_BYTES);
        check_value("rd_accepted", 32'(rd_accepted), 32'(is_rd));
        check_value("wr_accepted", 32'(wr_accepted), 32'(is_wr));
        check_value("data_buf_addr", 32'(data_buf_addr),
                    32'(is_wr ? wr_data_buf_addr : rd_data_buf_addr_r));
      end
    end else begin
      check_value("rd_accepted", 32'(rd_accepted), 32'(0));
      check_value("wr_accepted", 32'(wr_accepted), 32'(0));
    end
    // Look-ahead request
    pres       = m_rdy ? m_s1 : m_s2;
    pres_valid = m_rdy ? m_s1_valid : m_s2_valid;
    if (pres_valid) begin
      decode_addr(pres.addr, e_rank, e_group, e_bank, e_row, e_col);
      check_value("rank", 32'(rank), 32'(e_rank));
      check_value("group", 32'(group), 32'(e_group));
      check_value("bank", 32'(bank), 32'(e_bank));
      check_value("row", 32'(row), 32'(e_row));
      check_value("col", 32'(col), 32'(e_col));
      check_value("cmd", 32'(cmd), 32'(pres.cmd));
      check_value("size", 32'(size), 32'(pres.sz));
      check_value("hi_priority", 32'(hi_priority), 32'(pres.hi_pri));
      check_value("autoprecharge", 32'(autoprecharge), 32'(pres.ap));
    end
  endtask

  // **************************************************************************
  // Main sequence
  // **************************************************************************
  initial begin
    errors     = 0;
    checks     = 0;
    consumed   = 0;
    lfsr_state = LFSR_SEED;
    rst        = 1'b1;
    drive_idle(1'b0);
    m_rdy      = 1'b0;
    m_s1_valid = 1'b0;
    m_s2_valid = 1'b0;
    m_s1       = '0;
    m_s2       = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    // First check sees the state left by reset
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      check_outputs();
      rst = 1'b0;
      drive_random(cyc);
      update_model();
      @(negedge clk);
    end
    // Let the pipeline empty out
    for (int cyc = 0; cyc < DRAIN_CYCLES; cyc++) begin
      check_outputs();
      drive_idle(1'b1);
      update_model();
      @(negedge clk);
    end
    check_outputs();
    assert (pend_q.size() == 0) else begin
      errors++;
      $display("%0d accepted requests never got a use_addr pulse", pend_q.size());
    end
    $display("Checks: %0d, errors: %0d, requests consumed: %0d", checks, errors, consumed);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the run finished", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
